//--- files.f
rtl/memq_pkg.sv
rtl/iq_store.sv
rtl/head_tracker.sv
rtl/mem_issue.sv
rtl/mem_issue_top.sv
test/clk_gen.sv
test/mem_issue_checker.sv
test/mem_issue_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal -f files.f --top-module mem_issue_tb \
	--Mdir obj_dir -o sim; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1

//--- test/mem_issue_tb.sv
module mem_issue_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import memq_pkg::*;

	// operation classes {mem, load, store, fc}
	localparam mem_op_t NO = 4'b0000;
	localparam mem_op_t LD = 4'b1100;
	localparam mem_op_t ST = 4'b1010;
	localparam mem_op_t FC = 4'b0001;

	// one cycle of inputs and the outputs expected two rising edges later
	typedef struct packed {
		logic [3:0] tst;
		logic enq;
		mem_op_t op;
		logic agen_v;
		que_ndx_t ndx;
		address_t addr;
		logic commit;
		que_bitmask_t stomp;
		que_bitmask_t iss;
		logic full;
	} row_t;

	logic clk, rst, enq, agen_v, commit, full;
	mem_op_t enq_op;
	que_ndx_t agen_ndx;
	address_t agen_addr;
	que_bitmask_t stomp, memissue;

	row_t rows[$];
	int cur_test = 0;
	int last_test = 0;
	int tests = 0;
	int checks = 0;
	int errors = 0;
	int test_errs = 0;
	int cycles = 0;
	int limit = 1000;

	clk_gen u_clk (.clk(clk));

	mem_issue_top DUT (.clk(clk), .rst(rst), .enq(enq), .enq_op(enq_op), .agen_v(agen_v),
		.agen_ndx(agen_ndx), .agen_addr(agen_addr), .commit(commit), .stomp(stomp),
		.memissue(memissue), .full(full));

	// ==============================
	// table building
	// ==============================

	task automatic add(input logic e, input mem_op_t op, input logic a, input que_ndx_t n,
		input address_t ad, input logic c, input que_bitmask_t s, input que_bitmask_t iss,
		input logic f);
		row_t r;
		r = {4'(cur_test), e, op, a, n, ad, c, s, iss, f};
		rows.push_back(r);
	endtask

	task automatic enq_row(input mem_op_t op, input logic f);
		add(1'b1, op, 1'b0, '0, '0, 1'b0, '0, '0, f);
	endtask

	task automatic agen_row(input que_ndx_t n, input address_t ad, input que_bitmask_t iss,
		input logic f);
		add(1'b0, NO, 1'b1, n, ad, 1'b0, '0, iss, f);
	endtask

	task automatic idle_row(input que_bitmask_t iss, input logic f);
		add(1'b0, NO, 1'b0, '0, '0, 1'b0, '0, iss, f);
	endtask

	task automatic commit_row(input que_bitmask_t iss);
		add(1'b0, NO, 1'b0, '0, '0, 1'b1, '0, iss, 1'b0);
	endtask

	// expected grants follow the age and line rules, worked out row by row
	task automatic build_table();
		que_ndx_t s;
		cur_test = 1;
		enq_row(LD, 0);
		agen_row(0, 32'h100, 8'h01, 0);
		idle_row(0, 0);
		idle_row(0, 0);
		commit_row(0);
		// slot 2 gets its address first but waits on slot 1
		cur_test = 2;
		enq_row(LD, 0);
		enq_row(LD, 0);
		agen_row(2, 32'h200, 0, 0);
		agen_row(1, 32'h300, 8'h02, 0);
		idle_row(0, 0);
		idle_row(8'h04, 0);
		idle_row(0, 0);
		commit_row(0);
		commit_row(0);
		cur_test = 3;
		enq_row(LD, 0);
		enq_row(LD, 0);
		agen_row(4, 32'h400, 0, 0);
		idle_row(0, 0);
		agen_row(3, 32'h404, 8'h08, 0);
		idle_row(0, 0);
		idle_row(8'h10, 0);
		idle_row(0, 0);
		commit_row(0);
		commit_row(0);
		// fc in slot 5, a load in slot 6 passes it, the store in slot 7 does not
		cur_test = 4;
		enq_row(FC, 0);
		enq_row(LD, 0);
		enq_row(ST, 0);
		agen_row(6, 32'h600, 8'h40, 0);
		agen_row(7, 32'h700, 0, 0);
		idle_row(0, 0);
		idle_row(0, 0);
		commit_row(8'h80);
		idle_row(0, 0);
		commit_row(0);
		commit_row(0);
		// slot 0 is stomped in the cycle after its address arrives
		// slot 1 sits on another line, so the stomped slot no longer holds it back
		cur_test = 5;
		enq_row(LD, 0);
		enq_row(LD, 0);
		agen_row(1, 32'h800, 0, 0);
		agen_row(0, 32'h810, 8'h02, 0);
		add(0, NO, 0, 0, 0, 0, 8'h01, 0, 0);
		idle_row(0, 0);
		commit_row(0);
		commit_row(0);
		// fill from slot 2 around the ring, then random addresses on distinct lines
		cur_test = 6;
		for (int k = 0; k < QENTRIES; k++) begin
			enq_row(LD, k >= QENTRIES - 2);
		end
		enq_row(LD, 1);
		for (int k = 0; k < QENTRIES; k++) begin
			s = que_ndx_t'(2 + k);
			agen_row(s, ($urandom() & 32'hFFFF_FF8F) | (k << LINE_LSB), 8'h01 << s, 1);
			idle_row(0, k != QENTRIES - 1);
		end
		for (int k = 0; k < 6; k++) begin
			commit_row(0);
		end
		// head has wrapped to slot 0, two stores sit at slots 2 and 3
		// the younger store waits until the older one is committed
		enq_row(ST, 0);
		enq_row(ST, 0);
		agen_row(3, 32'h900, 0, 0);
		agen_row(2, 32'h908, 8'h04, 0);
		idle_row(0, 0);
		commit_row(0);
		commit_row(0);
		commit_row(8'h08);
		idle_row(0, 0);
	endtask

	// ==============================
	// checking
	// ==============================

	task automatic check_mask(input string name, input que_bitmask_t exp, input que_bitmask_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			test_errs++;
			$display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			test_errs++;
			$display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic report_test(input int t);
		$display("test %0d: %s, %0d mismatches", t, test_errs == 0 ? "passed" : "failed",
			test_errs);
	endtask

	task automatic check_row(input row_t r);
		if (int'(r.tst) != last_test) begin
			if (last_test > 0) begin
				report_test(last_test);
			end
			last_test = r.tst;
			test_errs = 0;
			tests++;
		end
		check_mask("memissue", r.iss, memissue);
		check_bit("full", r.full, full);
	endtask

	task automatic drive(input row_t r);
		enq = r.enq;
		enq_op = r.op;
		agen_v = r.agen_v;
		agen_ndx = r.ndx;
		agen_addr = r.addr;
		commit = r.commit;
		stomp = r.stomp;
	endtask

	initial begin
		void'($urandom(96077));
		rst = 1'b1;
		drive('0);
		build_table();
		limit = 2 * rows.size() + 50;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < rows.size() + 2; i++) begin
			@(negedge clk);
			if (i >= 2) begin
				check_row(rows[i - 2]);
			end
			if (i < rows.size()) begin
				drive(rows[i]);
			end else begin
				drive('0);
			end
		end
		report_test(last_test);
		$display("%0d tests, %0d checks, %0d mismatches", tests, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// stops a run that never reaches the end of the table
	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("run stopped after %0d cycles without finishing the table", limit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

endmodule

//--- test/mem_issue_checker.sv
module mem_issue_checker (
	input logic clk,
	input logic rst,
	input memq_pkg::que_bitmask_t memissue
);
	timeunit 1ns;
	timeprecision 100ps;

	// the arbiter grants at most one slot per cycle
	assert property (@(posedge clk) disable iff (rst) $onehot0(memissue))
		else $error("memissue has more than one bit set");

	// a grant lasts exactly one cycle
	assert property (@(posedge clk) disable iff (rst) (memissue & $past(memissue)) == '0)
		else $error("memissue bit held for two cycles");

	// nothing can be granted in the first cycle out of reset
	assert property (@(posedge clk) $fell(rst) |-> memissue == '0)
		else $error("memissue set right after reset");

endmodule

bind mem_issue mem_issue_checker u_check (.clk(clk), .rst(rst), .memissue(memissue));

//--- test/clk_gen.sv
module clk_gen (
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period, starting low
	initial clk = 1'b0;
	always #4 clk = ~clk;

endmodule

//--- rtl/mem_issue_top.sv
module mem_issue_top (
	input  logic clk,
	input  logic rst,
	input  logic enq,
	input  memq_pkg::mem_op_t enq_op,
	input  logic agen_v,
	input  memq_pkg::que_ndx_t agen_ndx,
	input  memq_pkg::address_t agen_addr,
	input  logic commit,
	input  memq_pkg::que_bitmask_t stomp,
	output memq_pkg::que_bitmask_t memissue,
	output logic full
);
	import memq_pkg::*;

	// queue contents and the slots that want memory
	iq_entry_t [QENTRIES-1:0] iq;
	que_bitmask_t memready;

	// slot numbers from oldest to youngest
	que_order_t order;

	// ==============================
	// entry storage
	// ==============================

	iq_store u_store (
		.clk(clk),
		.rst(rst),
		.enq(enq),
		.enq_op(enq_op),
		.agen_v(agen_v),
		.agen_ndx(agen_ndx),
		.agen_addr(agen_addr),
		.commit(commit),
		.order(order),
		.stomp(stomp),
		.memissue(memissue),
		.iq(iq),
		.memready(memready),
		.full(full)
	);

	// head pointer and age order
	head_tracker u_head (
		.clk(clk),
		.rst(rst),
		.commit(commit),
		.order(order)
	);

	// the grant goes out of the block and back into storage to set out
	mem_issue u_issue (
		.clk(clk),
		.rst(rst),
		.order(order),
		.memready(memready),
		.stomp(stomp),
		.iq(iq),
		.memissue(memissue)
	);

endmodule

//--- rtl/mem_issue.sv
module mem_issue (
	input  logic clk,
	input  logic rst,
	input  memq_pkg::que_order_t order,
	input  memq_pkg::que_bitmask_t memready,
	input  memq_pkg::que_bitmask_t stomp,
	input  memq_pkg::iq_entry_t [memq_pkg::QENTRIES-1:0] iq,
	output memq_pkg::que_bitmask_t memissue
);
	import memq_pkg::*;

	// slots that pass every ordering rule this cycle
	que_bitmask_t can_issue;

	// scratch values used while scanning one age position
	iq_entry_t young;
	iq_entry_t old;
	logic ok;
	logic old_safe;

	// true when two addresses fall in the same 16-byte line
	function automatic logic same_line(input address_t a, input address_t b);
		return a[$bits(address_t)-1:LINE_LSB] == b[$bits(address_t)-1:LINE_LSB];
	endfunction

	// ==============================
	// ordering rules
	// ==============================

	// each age position is checked against every position older than it
	// an invalid slot is a hole in the ring (stomped or never filled) and never blocks
	always_comb begin
		can_issue = '0;
		young = '0;
		old = '0;
		ok = 1'b0;
		old_safe = 1'b0;
		for (int i = 0; i < QENTRIES; i++) begin
			young = iq[order[i]];

			// rule 1, the entry itself must be ready and not stomped
			ok = memready[order[i]] & ~stomp[order[i]];

			for (int j = 0; j < i; j++) begin
				old = iq[order[j]];

				// rule 2, an older entry that wants memory goes first
				if (memready[order[j]]) begin
					ok = 1'b0;
				end

				// rule 3, an older memory entry is harmless once it has gone out,
				// or once its address is known and sits on another line
				old_safe = ~old.v | ~old.mem | (old.agen & old.out)
					| (old.a1_v & ~same_line(old.a1, young.a1));
				if (!old_safe) begin
					ok = 1'b0;
				end

				// rule 4, a store cannot pass an older store,
				// nor an older branch that might still be undone
				if (young.store && old.v && (old.store || old.fc)) begin
					ok = 1'b0;
				end
			end

			can_issue[order[i]] = ok;
		end
	end

	// ==============================
	// grant register
	// ==============================

	// the queue marks an entry as out one edge after its grant appears,
	// so last cycle's grant is masked here to keep it from firing twice
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			memissue <= '0;
		end else begin
			memissue <= can_issue & ~memissue;
		end
	end

endmodule

//--- rtl/head_tracker.sv
module head_tracker (
	input  logic clk,
	input  logic rst,
	input  logic commit,
	output memq_pkg::que_order_t order
);
	import memq_pkg::*;

	// slot number of the oldest entry
	que_ndx_t head;

	// ==============================
	// head pointer
	// ==============================

	// the head moves one slot per commit and wraps past the last slot
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			head <= '0;
		end else if (commit) begin
			head <= head + 1'b1;
		end
	end

	// ==============================
	// age order
	// ==============================

	// position k in age is the slot k steps after the head
	// the index width makes the addition wrap modulo the queue size
	always_comb begin
		for (int k = 0; k < QENTRIES; k++) begin
			order[k] = head + que_ndx_t'(k);
		end
	end

endmodule

//--- rtl/iq_store.sv
module iq_store (
	input  logic clk,
	input  logic rst,
	input  logic enq,
	input  memq_pkg::mem_op_t enq_op,
	input  logic agen_v,
	input  memq_pkg::que_ndx_t agen_ndx,
	input  memq_pkg::address_t agen_addr,
	input  logic commit,
	input  memq_pkg::que_order_t order,
	input  memq_pkg::que_bitmask_t stomp,
	input  memq_pkg::que_bitmask_t memissue,
	output memq_pkg::iq_entry_t [memq_pkg::QENTRIES-1:0] iq,
	output memq_pkg::que_bitmask_t memready,
	output logic full
);
	import memq_pkg::*;

	// allocation pointer, the next free slot of the ring
	que_ndx_t tail;

	// number of slots between head and tail
	// a stomped slot stays in the ring until it is committed
	logic [$clog2(QENTRIES):0] count;

	// an allocation that is actually taken this cycle
	logic enq_ok;

	assign full = (count == QENTRIES);
	assign enq_ok = enq & ~full;

	// ==============================
	// memory-ready mask
	// ==============================

	// an entry wants memory once its address is known and it has not gone out
	// a stomped entry drops out of the mask in the same cycle
	always_comb begin
		for (int i = 0; i < QENTRIES; i++) begin
			memready[i] = iq[i].v & iq[i].mem & iq[i].a1_v & ~iq[i].out & ~stomp[i];
		end
	end

	// ==============================
	// entry and pointer registers
	// ==============================

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			iq <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			// a new entry starts with no address and not yet issued
			if (enq_ok) begin
				iq[tail].v <= 1'b1;
				iq[tail].mem <= enq_op.mem;
				iq[tail].load <= enq_op.load;
				iq[tail].store <= enq_op.store;
				iq[tail].fc <= enq_op.fc;
				iq[tail].agen <= 1'b0;
				iq[tail].a1_v <= 1'b0;
				iq[tail].out <= 1'b0;
				tail <= tail + 1'b1;
			end

			// address generation writes back one slot
			if (agen_v) begin
				iq[agen_ndx].a1 <= agen_addr;
				iq[agen_ndx].a1_v <= 1'b1;
				iq[agen_ndx].agen <= 1'b1;
			end

			// the arbiter flagged these slots last cycle, so they are on their way
			for (int i = 0; i < QENTRIES; i++) begin
				if (memissue[i]) begin
					iq[i].out <= 1'b1;
				end
			end

			// retiring frees the head slot, the head pointer moves in head_tracker
			if (commit) begin
				iq[order[0]].v <= 1'b0;
			end

			// stomp is applied last so it wins over a same-cycle allocation
			for (int i = 0; i < QENTRIES; i++) begin
				if (stomp[i]) begin
					iq[i].v <= 1'b0;
				end
			end

			// ring occupancy follows allocations and commits only
			if (enq_ok && !commit) begin
				count <= count + 1'b1;
			end else if (!enq_ok && commit) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

//--- rtl/memq_pkg.sv
package memq_pkg;

	// ==============================
	// queue geometry
	// ==============================

	// the issue queue is a ring of eight slots
	localparam int QENTRIES = 8;

	// low address bits that fall inside one 16-byte line
	// two accesses conflict when the bits above these match
	localparam int LINE_LSB = 4;

	// ==============================
	// basic vector types
	// ==============================

	// index of one queue slot
	typedef logic [$clog2(QENTRIES)-1:0] que_ndx_t;

	// one bit per slot, indexed by slot number and not by age
	typedef logic [QENTRIES-1:0] que_bitmask_t;

	// a memory byte address
	typedef logic [31:0] address_t;

	// ==============================
	// entry records
	// ==============================

	// operation class carried by an allocation request
	// fc marks a flow-control instruction that may still be undone
	typedef struct packed {
		logic mem;
		logic load;
		logic store;
		logic fc;
	} mem_op_t;

	// one queue slot as seen by the memory arbiter
	typedef struct packed {
		logic v;
		logic mem;
		logic load;
		logic store;
		logic fc;
		logic agen;
		logic a1_v;
		logic out;
		address_t a1;
	} iq_entry_t;

	// slot numbers listed by age, element 0 is the head (oldest)
	typedef que_ndx_t [QENTRIES-1:0] que_order_t;

endpackage
